// File: compile.f
verilog/isa_pkg.sv
verilog/machine_pkg.sv
verilog/instruction_decoder.sv
verilog/cycle_controller.sv
verilog/alu_execute.sv
verilog/result_writeback.sv
verilog/cpu_top.sv
verification/memory_model.sv
verification/cpu_tb.sv

// File: Bender.yml
package:
  name: accumulator_cpu

sources:
  - verilog/isa_pkg.sv
  - verilog/machine_pkg.sv
  - verilog/instruction_decoder.sv
  - verilog/cycle_controller.sv
  - verilog/alu_execute.sv
  - verilog/result_writeback.sv
  - verilog/cpu_top.sv
  - target: simulation
    files:
      - verification/memory_model.sv
      - verification/cpu_tb.sv

// File: verification/cpu_tb.sv
`timescale 1ns/1ns

module cpu_tb;
  import isa_pkg::*;
  import machine_pkg::*;

  localparam int          CLOCK_PERIOD     = 100;
  localparam int          MAX_INSTR_CYCLES = 14;
  localparam int          SLACK_CYCLES     = 50;
  localparam int          STAY_LIMIT       = 20; // idle bus cycles that mean halted
  localparam int          MAX_STEPS        = 500;
  localparam logic [31:0] LCG_SEED         = 32'd97500;

  logic    CLOCK;
  logic    RESET;
  word_t   read_bus;
  mem_op_t ctrl_bus;
  word_t   addr_bus;
  word_t   write_bus;
  word_t   register_a;

  word_t       image [0:255]; // memory contents at the start of a test
  word_t       ref_mem [0:255];
  word_t       exp_wr_addr [0:63];
  word_t       exp_wr_data [0:63];
  word_t       exp_acc;
  word_t       next_wr_addr;
  word_t       next_wr_data;
  int          wr_count;
  int          wr_index;
  logic        write_half;
  int          stay_count;
  logic        halted;
  int          code_len;
  logic [31:0] lcg_state;
  time         deadline;
  string       test_name;

  cpu_top DUT (
    .CLOCK      (CLOCK),
    .RESET      (RESET),
    .read_bus   (read_bus),
    .ctrl_bus   (ctrl_bus),
    .addr_bus   (addr_bus),
    .write_bus  (write_bus),
    .register_a (register_a)
  );

  memory_model ram (
    .CLOCK     (CLOCK),
    .ctrl_bus  (ctrl_bus),
    .addr_bus  (addr_bus),
    .write_bus (write_bus),
    .read_bus  (read_bus)
  );

  initial begin
    CLOCK = 1'b0;
    forever #(CLOCK_PERIOD / 2) CLOCK = ~CLOCK;
  end

  task automatic abort_run();
    $display("Test failed");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic report_mismatch(input string what, input word_t expected,
                                 input word_t actual);
    $display("[FAIL] %s %s: expected %02h, actual %02h", test_name, what, expected, actual);
    abort_run();
  endtask

  function automatic word_t random_byte();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[23:16];
  endfunction

  function automatic word_t data_address();
    return 8'h80 | random_byte(); // data lives above the code
  endfunction

  task automatic emit(input int length, input word_t b0, input word_t b1 = '0,
                      input word_t b2 = '0);
    image[code_len] = b0;
    if (length > 1)
      image[code_len + 1] = b1;
    if (length > 2)
      image[code_len + 2] = b2;
    code_len = code_len + length;
  endtask

  task automatic build_program(input word_t terminator);
    code_len = 0;
    for (int i = 0; i < 256; i++)
      image[i] = word_t'(i * 37 + 11); // odd stride makes the fill depend on every address bit
    for (int r = 0; r < 2; r++) begin
      emit(2, 8'h03, random_byte());                  // MOV A, #imm
      emit(2, 8'h13, random_byte());                  // ADD A, #imm
      emit(2, 8'h12, data_address());                 // ADD A, [m]
      emit(2, 8'h08, data_address());                 // MOV [m], A
      emit(3, 8'h1B, random_byte(), data_address());  // ADD [m], #imm
      emit(3, 8'h1A, data_address(), data_address()); // ADD [m], [m]
      emit(3, 8'h0A, data_address(), data_address()); // MOV [m], [m]
      emit(1, NOP_BYTE);
      emit(2, 8'hC0, 8'd4);                           // jump over the next two
      emit(2, 8'h03, random_byte());
      emit(2, 8'h08, data_address());
      emit(1, 8'h10);                                 // ADD A, A
      emit(3, 8'h0B, random_byte(), data_address());  // MOV [m], #imm
    end
    emit(1, terminator);
    emit(2, 8'h03, 8'h5A); // never reached
  endtask

  // instruction-level model of the ISA, fills exp_acc and the expected writes
  function automatic int run_reference();
    word_t      ip;
    word_t      acc;
    word_t      opcode;
    word_t      imm;
    word_t      src_value;
    word_t      dst_addr;
    word_t      dst_value;
    word_t      result;
    logic [1:0] src_field;
    logic [1:0] dst_field;
    logic       running;
    int         executed;
    for (int i = 0; i < 256; i++)
      ref_mem[i] = image[i];
    ip = '0;
    acc = '0;
    dst_addr = '0;
    running = 1'b1;
    executed = 0;
    wr_count = 0;
    while (running && executed < MAX_STEPS) begin
      opcode = ref_mem[ip];
      ip = ip + 8'd1;
      executed++;
      src_field = opcode[1:0];
      dst_field = opcode[3:2];
      if (opcode == NOP_BYTE) begin
        running = 1'b1;
      end else if (opcode[7:4] == 4'hC) begin
        imm = ref_mem[ip];
        ip = ip + 8'd1 + imm; // offset counts from the byte after it
      end else if (opcode[7:5] == 3'b000 && src_field != 2'b01
                   && dst_field inside {2'b00, 2'b10}) begin
        imm = '0;
        if (src_field[1]) begin
          imm = ref_mem[ip];
          ip = ip + 8'd1;
        end
        case (src_field)
          2'b00:   src_value = acc;
          2'b10:   src_value = ref_mem[imm];
          default: src_value = imm;
        endcase
        dst_value = acc;
        if (dst_field == 2'b10) begin
          dst_addr = ref_mem[ip];
          ip = ip + 8'd1;
          dst_value = ref_mem[dst_addr];
        end
        result = opcode[4] ? word_t'(dst_value + src_value) : src_value;
        if (dst_field == 2'b10) begin
          ref_mem[dst_addr] = result;
          exp_wr_addr[wr_count] = dst_addr;
          exp_wr_data[wr_count] = result;
          wr_count++;
        end else begin
          acc = result;
        end
      end else begin
        running = 1'b0; // HLT, dropped encodings and unknown opcodes
      end
    end
    exp_acc = acc;
    return executed;
  endfunction

  task automatic run_test(input string name, input word_t terminator);
    int instr_count;
    RESET <= 1'b1;
    @(posedge CLOCK);
    test_name = name;
    build_program(terminator);
    instr_count = run_reference();
    for (int i = 0; i < 256; i++)
      ram.mem[i] = image[i];
    @(posedge CLOCK);
    RESET <= 1'b0;
    deadline = $time + (instr_count * MAX_INSTR_CYCLES + SLACK_CYCLES) * CLOCK_PERIOD;
    wait (halted == 1'b1);
    repeat (2) @(posedge CLOCK); // halt checks run on these edges
  endtask

  assign next_wr_addr = exp_wr_addr[wr_index];
  assign next_wr_data = exp_wr_data[wr_index];
  assign halted = (stay_count == STAY_LIMIT);

  always @(posedge CLOCK) begin
    if (RESET) begin
      wr_index   <= 0;
      write_half <= 1'b0;
      stay_count <= 0;
    end else begin
      if (ctrl_bus == MEM_WRITE) begin
        write_half <= ~write_half;
        if (write_half)
          wr_index <= wr_index + 1; // burst done
      end
      if (ctrl_bus != MEM_STAY)
        stay_count <= 0;
      else if (stay_count < STAY_LIMIT)
        stay_count <= stay_count + 1;
    end
  end

  always @(posedge CLOCK) begin
    if (!RESET && $time > deadline) begin
      $display("ERROR: %s: the CPU did not halt in time", test_name);
      abort_run();
    end
  end

  write_expected: assert property (@(posedge CLOCK) disable iff (RESET)
    ctrl_bus == MEM_WRITE |-> wr_index < wr_count)
    else report_mismatch("write count", word_t'(wr_count), word_t'(wr_count + 1));

  write_address: assert property (@(posedge CLOCK) disable iff (RESET)
    ctrl_bus == MEM_WRITE |-> addr_bus == next_wr_addr)
    else report_mismatch("write address", $sampled(next_wr_addr), $sampled(addr_bus));

  write_data: assert property (@(posedge CLOCK) disable iff (RESET)
    ctrl_bus == MEM_WRITE |-> write_bus == next_wr_data)
    else report_mismatch("write data", $sampled(next_wr_data), $sampled(write_bus));

  halt_accumulator: assert property (@(posedge CLOCK) disable iff (RESET)
    halted |-> register_a == exp_acc)
    else report_mismatch("register_a", $sampled(exp_acc), $sampled(register_a));

  halt_no_pending_write: assert property (@(posedge CLOCK) disable iff (RESET)
    halted |-> wr_index == wr_count)
    else report_mismatch("writes done", word_t'(wr_count), word_t'(wr_index));

  halt_bus_idle: assert property (@(posedge CLOCK) disable iff (RESET)
    halted |-> ctrl_bus == MEM_STAY)
    else report_mismatch("ctrl_bus after halt", word_t'(MEM_STAY),
                         word_t'($sampled(ctrl_bus)));

  halt_stays_quiet: assert property (@(posedge CLOCK) disable iff (RESET)
    halted |-> $stable(register_a))
    else report_mismatch("register_a after halt", $past(register_a), $sampled(register_a));

  initial begin
    RESET = 1'b1;
    lcg_state = LCG_SEED;
    deadline = '1;
    test_name = "startup";
    run_test("halt_instruction", HLT_BYTE);
    run_test("dropped_encoding", 8'h11); // ADD with register-indirect source
    $display("Test passed");
    $finish;
  end

endmodule

// File: verification/memory_model.sv
`timescale 1ns/1ns

module memory_model (
  input  logic                   CLOCK
  , input  machine_pkg::mem_op_t ctrl_bus
  , input  machine_pkg::word_t   addr_bus
  , input  machine_pkg::word_t   write_bus
  , output machine_pkg::word_t   read_bus
);
  import machine_pkg::*;

  word_t mem [0:255]; // loaded by the testbench while the CPU is in reset

  initial begin
    read_bus = '0;
  end

  // read data is ready one cycle after the address, so in the second cycle of an access
  always @(posedge CLOCK) begin
    if (ctrl_bus == MEM_WRITE)
      mem[addr_bus] <= write_bus; // stored on both cycles of the burst
    else if (ctrl_bus == MEM_READ)
      read_bus <= mem[addr_bus];
  end

endmodule

// File: verilog/cpu_top.sv
`timescale 1ns/1ns

module cpu_top (
  input  logic                   CLOCK
  , input  logic                 RESET
  , input  machine_pkg::word_t   read_bus
  , output machine_pkg::mem_op_t ctrl_bus
  , output machine_pkg::word_t   addr_bus
  , output machine_pkg::word_t   write_bus
  , output machine_pkg::word_t   register_a
);
  import isa_pkg::*;
  import machine_pkg::*;

  stage_t         stage;
  word_t          opcode_byte;
  operands_t      operands;
  decoded_instr_t instr;
  word_t          result;

  cycle_controller controller (
    .CLOCK       (CLOCK),
    .RESET       (RESET),
    .read_bus    (read_bus),
    .instr       (instr),
    .stage       (stage),
    .opcode_byte (opcode_byte),
    .operands    (operands),
    .addr_bus    (addr_bus),
    .ctrl_bus    (ctrl_bus)
  );

  instruction_decoder decoder (
    .CLOCK       (CLOCK),
    .RESET       (RESET),
    .stage       (stage),
    .opcode_byte (opcode_byte),
    .instr       (instr)
  );

  alu_execute alu (
    .instr      (instr),
    .operands   (operands),
    .register_a (register_a),
    .result     (result)
  );

  result_writeback writeback (
    .CLOCK      (CLOCK),
    .RESET      (RESET),
    .stage      (stage),
    .instr      (instr),
    .result     (result),
    .register_a (register_a), // accumulator is visible at the top
    .write_bus  (write_bus)
  );

endmodule

// File: verilog/result_writeback.sv
`timescale 1ns/1ns

module result_writeback (
  input  logic                      CLOCK
  , input  logic                    RESET
  , input  machine_pkg::stage_t     stage
  , input  isa_pkg::decoded_instr_t instr
  , input  machine_pkg::word_t      result
  , output machine_pkg::word_t      register_a
  , output machine_pkg::word_t      write_bus
);
  import isa_pkg::*;
  import machine_pkg::*;

  always_ff @(posedge CLOCK) begin
    if (RESET) begin
      register_a <= '0;
      write_bus  <= '0;
    end else begin
      if (stage == WRITE_REG)
        register_a <= result;
      // held steady through both write cycles
      if (stage == EXECUTE && instr.dst == OPND_MEM_IMM)
        write_bus <= result;
    end
  end

  acc_updates_after_write_reg: assert property (@(posedge CLOCK) disable iff (RESET)
    !$stable(register_a) |-> $past(stage) == WRITE_REG);

endmodule

// File: verilog/alu_execute.sv
`timescale 1ns/1ns

module alu_execute (
  input  isa_pkg::decoded_instr_t  instr
  , input  machine_pkg::operands_t operands
  , input  machine_pkg::word_t     register_a
  , output machine_pkg::word_t     result
);
  import isa_pkg::*;
  import machine_pkg::*;

  word_t src_value;
  word_t dst_value; // value at the destination before the update

  always_comb begin
    case (instr.src)
      OPND_REG_A:   src_value = register_a;
      OPND_MEM_IMM: src_value = operands.src_data;
      OPND_IMM:     src_value = operands.imm;
      default:      src_value = '0;
    endcase
  end

  assign dst_value = (instr.dst == OPND_MEM_IMM) ? operands.dst_data : register_a;

  always_comb begin
    case (instr.op)
      OP_MOV:  result = src_value;
      OP_ADD:  result = dst_value + src_value; // wraps at 8 bits
      default: result = dst_value;
    endcase
  end

endmodule

// File: verilog/cycle_controller.sv
`timescale 1ns/1ns

module cycle_controller (
  input  logic                      CLOCK
  , input  logic                    RESET
  , input  machine_pkg::word_t      read_bus
  , input  isa_pkg::decoded_instr_t instr
  , output machine_pkg::stage_t     stage
  , output machine_pkg::word_t      opcode_byte
  , output machine_pkg::operands_t  operands
  , output machine_pkg::word_t      addr_bus
  , output machine_pkg::mem_op_t    ctrl_bus
);
  import isa_pkg::*;
  import machine_pkg::*;

  fetch_step_t step;      // earliest step still to be considered
  fetch_step_t cur_step;
  fetch_step_t next_step;
  logic        phase;     // second cycle of a bus access
  word_t       ip;

  // first operand step at or after from that this instruction needs
  function automatic fetch_step_t first_needed(fetch_step_t from, decoded_instr_t i);
    fetch_step_t s;
    s = STEP_DONE;
    if (from <= STEP_DST_DATA && i.op == OP_ADD && i.dst == OPND_MEM_IMM)
      s = STEP_DST_DATA;
    if (from <= STEP_DST_ADDR && i.dst == OPND_MEM_IMM)
      s = STEP_DST_ADDR;
    if (from <= STEP_SRC_DATA && i.src == OPND_MEM_IMM)
      s = STEP_SRC_DATA;
    if (from <= STEP_IMM && i.src inside {OPND_IMM, OPND_MEM_IMM})
      s = STEP_IMM;
    return s;
  endfunction

  assign cur_step  = first_needed(step, instr);
  assign next_step = (cur_step == STEP_DONE) ? STEP_DONE
                                             : first_needed(fetch_step_t'(cur_step + 3'd1), instr);

  always_comb begin
    ctrl_bus = MEM_STAY;
    addr_bus = '0;
    case (stage)
      FETCH_OP: begin
        ctrl_bus = MEM_READ;
        addr_bus = ip;
      end
      FETCH_OPERAND: begin
        if (cur_step != STEP_DONE) begin
          ctrl_bus = MEM_READ;
          case (cur_step)
            STEP_SRC_DATA: addr_bus = operands.imm;
            STEP_DST_DATA: addr_bus = operands.dst_addr;
            default:       addr_bus = ip; // immediate bytes follow the opcode
          endcase
        end
      end
      WRITE_MEM: begin
        ctrl_bus = MEM_WRITE;
        addr_bus = operands.dst_addr;
      end
      default: ;
    endcase
  end

  always_ff @(posedge CLOCK) begin
    if (RESET) begin
      stage <= FETCH_OP;
      step  <= STEP_IMM;
      phase <= 1'b0;
      ip    <= '0;
    end else begin
      case (stage)
        FETCH_OP: begin
          phase <= ~phase;
          if (phase) begin
            ip    <= ip + 8'd1;
            stage <= DECODE;
          end
        end
        DECODE: begin
          step  <= STEP_IMM;
          stage <= FETCH_OPERAND;
        end
        FETCH_OPERAND: begin
          if (instr.op == OP_HLT) begin
            stage <= HALTED;
          end else if (cur_step == STEP_DONE) begin
            stage <= EXECUTE; // nothing to fetch
          end else begin
            phase <= ~phase;
            if (phase) begin
              step <= next_step;
              if (cur_step == STEP_IMM || cur_step == STEP_DST_ADDR)
                ip <= ip + 8'd1;
              if (next_step == STEP_DONE)
                stage <= EXECUTE;
            end
          end
        end
        EXECUTE: begin
          if (instr.op == OP_JMP)
            ip <= ip + operands.imm; // relative to the byte after the offset
          case (instr.dst)
            OPND_REG_A:   stage <= WRITE_REG;
            OPND_MEM_IMM: stage <= WRITE_MEM;
            default:      stage <= FETCH_OP; // JMP and NOP
          endcase
        end
        WRITE_REG: stage <= FETCH_OP;
        WRITE_MEM: begin
          phase <= ~phase;
          if (phase)
            stage <= FETCH_OP;
        end
        default: stage <= HALTED;
      endcase
    end
  end

  always_ff @(posedge CLOCK) begin
    if (stage == FETCH_OP && phase)
      opcode_byte <= read_bus;
    if (stage == FETCH_OPERAND && phase) begin
      case (cur_step)
        STEP_IMM:      operands.imm      <= read_bus;
        STEP_SRC_DATA: operands.src_data <= read_bus;
        STEP_DST_ADDR: operands.dst_addr <= read_bus;
        STEP_DST_DATA: operands.dst_data <= read_bus;
        default: ;
      endcase
    end
  end

  write_only_in_write_mem: assert property (@(posedge CLOCK) disable iff (RESET)
    ctrl_bus == MEM_WRITE |-> stage == WRITE_MEM);

  halted_is_final: assert property (@(posedge CLOCK) disable iff (RESET)
    stage == HALTED |=> stage == HALTED);

endmodule

// File: verilog/instruction_decoder.sv
`timescale 1ns/1ns

module instruction_decoder (
  input  logic                    CLOCK
  , input  logic                  RESET
  , input  machine_pkg::stage_t   stage
  , input  machine_pkg::word_t    opcode_byte
  , output isa_pkg::decoded_instr_t instr
);
  import isa_pkg::*;
  import machine_pkg::*;

  logic [OPCODE_MSB-OPCODE_LSB:0] opcode_field;
  logic [DST_MSB-DST_LSB:0]       dst_field;
  logic [SRC_MSB-SRC_LSB:0]       src_field;
  logic                           fields_ok;
  decoded_instr_t                 next_instr;

  assign opcode_field = opcode_byte[OPCODE_MSB:OPCODE_LSB];
  assign dst_field    = opcode_byte[DST_MSB:DST_LSB];
  assign src_field    = opcode_byte[SRC_MSB:SRC_LSB];

  // register-indirect and immediate destination are not supported
  assign fields_ok = (operand_t'(src_field) inside {OPND_REG_A, OPND_MEM_IMM, OPND_IMM})
                  && (operand_t'(dst_field) inside {OPND_REG_A, OPND_MEM_IMM});

  always_comb begin
    next_instr.op  = OP_HLT; // anything unknown stops the machine
    next_instr.src = OPND_NONE;
    next_instr.dst = OPND_NONE;
    if (opcode_byte == NOP_BYTE) begin
      next_instr.op = OP_NOP;
    end else if (opcode_byte == HLT_BYTE) begin
      next_instr.op = OP_HLT;
    end else if (opcode_field == JMP_CODE) begin
      next_instr.op  = OP_JMP;
      next_instr.src = OPND_IMM; // offset byte
    end else if ((opcode_field == MOV_CODE || opcode_field == ADD_CODE) && fields_ok) begin
      next_instr.op  = (opcode_field == ADD_CODE) ? OP_ADD : OP_MOV;
      next_instr.src = operand_t'(src_field);
      next_instr.dst = operand_t'(dst_field);
    end
  end

  always_ff @(posedge CLOCK) begin
    if (RESET) begin
      instr <= '{op: OP_NOP, src: OPND_NONE, dst: OPND_NONE};
    end else if (stage == DECODE) begin
      instr <= next_instr;
    end
  end

  no_imm_destination: assert property (@(posedge CLOCK) disable iff (RESET)
    instr.dst != OPND_IMM);

endmodule

// File: verilog/machine_pkg.sv
package machine_pkg;

  localparam int WORD_WIDTH = 8;

  typedef logic [WORD_WIDTH-1:0] word_t; // data and addresses

  typedef enum logic [2:0] {
    FETCH_OP,
    DECODE,
    FETCH_OPERAND,
    EXECUTE,
    WRITE_REG,
    WRITE_MEM,
    HALTED
  } stage_t;

  // order matters, operand fetch walks these upwards
  typedef enum logic [2:0] {
    STEP_IMM,
    STEP_SRC_DATA,
    STEP_DST_ADDR,
    STEP_DST_DATA,
    STEP_DONE
  } fetch_step_t;

  typedef enum logic [1:0] {
    MEM_STAY,
    MEM_READ,
    MEM_WRITE
  } mem_op_t;

  typedef struct packed {
    word_t imm;
    word_t src_data;
    word_t dst_addr;
    word_t dst_data;
  } operands_t;

endpackage

// File: verilog/isa_pkg.sv
package isa_pkg;

  // field positions in the opcode byte
  localparam int OPCODE_MSB = 7;
  localparam int OPCODE_LSB = 4;
  localparam int DST_MSB    = 3;
  localparam int DST_LSB    = 2;
  localparam int SRC_MSB    = 1;
  localparam int SRC_LSB    = 0;

  localparam logic [OPCODE_MSB-OPCODE_LSB:0] MOV_CODE = 4'b0000;
  localparam logic [OPCODE_MSB-OPCODE_LSB:0] ADD_CODE = 4'b0001;
  localparam logic [OPCODE_MSB-OPCODE_LSB:0] JMP_CODE = 4'b1100;

  localparam logic [7:0] NOP_BYTE = 8'hFE;
  localparam logic [7:0] HLT_BYTE = 8'hFF;

  typedef enum logic [2:0] {
    OP_MOV,
    OP_ADD,
    OP_JMP,
    OP_NOP,
    OP_HLT
  } opcode_t;

  // codes line up with the src/dst field encodings, 01 is unused there
  typedef enum logic [1:0] {
    OPND_REG_A   = 2'b00,
    OPND_NONE    = 2'b01,
    OPND_MEM_IMM = 2'b10,
    OPND_IMM     = 2'b11
  } operand_t;

  typedef struct packed {
    opcode_t  op;
    operand_t src;
    operand_t dst;
  } decoded_instr_t;

endpackage
